/* exec_pkg.sv */
/*
  Shared widths, operation encodings and defaults for the integer execute stage.
  Referenced by scoped name from every RTL file.
*/
package exec_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  parameter int NUM_CB_ENTRY = 16;
  typedef logic [$clog2(NUM_CB_ENTRY)-1:0] cb_index_t;

  // alu operation select
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_t;

  // encoded as the riscv funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd4,
    BR_GE  = 3'd5,
    BR_LTU = 3'd6,
    BR_GEU = 3'd7
  } br_cond_t;

  // which half of the unsigned product
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HI = 1'b1
  } mul_op_t;

  parameter int MUL_STAGES_DEFAULT = 3;

endpackage

/* result_if.sv */
/*
  Writeback group of one functional unit, passed to the commit latch.
*/
`timescale 1ns/1ns

interface result_if;

  logic                valid;
  exec_pkg::reg_idx_t  rd;
  exec_pkg::cb_index_t index;
  exec_pkg::word_t     wdata;

  // producing unit
  modport unit (
    output valid, rd, index, wdata
  );

  // execute-commit register
  modport commit (
    input valid, rd, index, wdata
  );

endinterface

/* arith_unit.sv */
/*
  Combinational ALU of the execute stage. Jumps reuse its writeback path
  to return the link value pc+4.
*/
`timescale 1ns/1ns

module arith_unit (
  input  logic                au_ena,
  input  logic                jump_instr,
  input  exec_pkg::alu_op_t   alu_op,
  input  exec_pkg::word_t     port_a,
  input  exec_pkg::word_t     port_b,
  input  exec_pkg::word_t     pc,
  input  exec_pkg::reg_idx_t  rd,
  input  exec_pkg::cb_index_t index,
  result_if.unit              res
);

  exec_pkg::word_t alu_out;
  logic [4:0]      shamt;

  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      exec_pkg::ALU_ADD:  alu_out = port_a + port_b;
      exec_pkg::ALU_SUB:  alu_out = port_a - port_b;
      exec_pkg::ALU_AND:  alu_out = port_a & port_b;
      exec_pkg::ALU_OR:   alu_out = port_a | port_b;
      exec_pkg::ALU_XOR:  alu_out = port_a ^ port_b;
      exec_pkg::ALU_SLL:  alu_out = port_a << shamt;
      exec_pkg::ALU_SRL:  alu_out = port_a >> shamt;
      exec_pkg::ALU_SRA:  alu_out = $signed(port_a) >>> shamt;
      exec_pkg::ALU_SLT:  alu_out = {31'b0, $signed(port_a) < $signed(port_b)};
      exec_pkg::ALU_SLTU: alu_out = {31'b0, port_a < port_b};
      default:            alu_out = '0;
    endcase
  end

  // jumps write their link register here
  assign res.valid = au_ena | jump_instr;
  assign res.wdata = jump_instr ? pc + 32'd4 : alu_out;
  assign res.rd    = rd;
  assign res.index = index;

endmodule

/* branch_resolve.sv */
/*
  Branch compare, branch and jump targets, and the mispredict redirect.
  redirect is combinational in the issue cycle; mispredict_ff is its registered copy.
*/
`timescale 1ns/1ns

module branch_resolve (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               branch_instr,
  input  logic               jump_instr,
  input  logic               jump_reg,
  input  logic               prediction,
  input  exec_pkg::br_cond_t br_cond,
  input  exec_pkg::word_t    port_a,
  input  exec_pkg::word_t    port_b,
  input  exec_pkg::word_t    pc,
  input  exec_pkg::word_t    immediate,
  output logic               taken,
  output exec_pkg::word_t    resolved_addr,
  output exec_pkg::word_t    redirect_addr,
  output logic               redirect,
  output logic               mispredict_ff
);

  logic            cond_true;
  logic            mispredict;
  exec_pkg::word_t branch_addr;
  exec_pkg::word_t jump_addr;
  exec_pkg::word_t pc4;

  always_comb begin
    case (br_cond)
      exec_pkg::BR_EQ:  cond_true = port_a == port_b;
      exec_pkg::BR_NE:  cond_true = port_a != port_b;
      exec_pkg::BR_LT:  cond_true = $signed(port_a) < $signed(port_b);
      exec_pkg::BR_GE:  cond_true = $signed(port_a) >= $signed(port_b);
      exec_pkg::BR_LTU: cond_true = port_a < port_b;
      exec_pkg::BR_GEU: cond_true = port_a >= port_b;
      default:          cond_true = 1'b0;
    endcase
  end

  assign pc4         = pc + 32'd4;
  assign branch_addr = pc + immediate;
  // jalr drops bit 0 of the sum
  assign jump_addr   = jump_reg ? ((port_a + immediate) & ~32'd1) : branch_addr;

  assign taken         = branch_instr & cond_true;
  assign resolved_addr = taken ? branch_addr : pc4;

  assign mispredict    = branch_instr & (prediction ^ cond_true);
  assign redirect      = jump_instr | mispredict;
  assign redirect_addr = jump_instr            ? jump_addr   :
                         (mispredict & taken)  ? branch_addr :
                                                 pc4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mispredict_ff <= 1'b0;
    end else begin
      mispredict_ff <= redirect;
    end
  end

endmodule

/* mul_pipe.sv */
/*
  Pipelined unsigned multiplier. Each stage carries a valid bit and the
  rd, index and half-select tags, so one multiply can issue every cycle.
*/
`timescale 1ns/1ns

module mul_pipe #(
  parameter int MUL_STAGES = 3
) (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                mul_ena,
  input  logic                stall,
  input  logic                flush,
  input  exec_pkg::mul_op_t   mul_op,
  input  exec_pkg::word_t     port_a,
  input  exec_pkg::word_t     port_b,
  input  exec_pkg::reg_idx_t  rd,
  input  exec_pkg::cb_index_t index,
  result_if.unit              res
);

  localparam int LAST = MUL_STAGES - 1;

  logic [MUL_STAGES-1:0] vld_q;
  logic [63:0]           prod_q [MUL_STAGES];
  exec_pkg::reg_idx_t    rd_q   [MUL_STAGES];
  exec_pkg::cb_index_t   idx_q  [MUL_STAGES];
  exec_pkg::mul_op_t     op_q   [MUL_STAGES];

  // flush kills everything in flight, stall freezes it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vld_q <= '0;
    end else if (flush) begin
      vld_q <= '0;
    end else if (!stall) begin
      vld_q[0] <= mul_ena;
      for (int i = 1; i < MUL_STAGES; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall) begin
      prod_q[0] <= 64'(port_a) * 64'(port_b);
      rd_q[0]   <= rd;
      idx_q[0]  <= index;
      op_q[0]   <= mul_op;
      for (int i = 1; i < MUL_STAGES; i++) begin
        prod_q[i] <= prod_q[i-1];
        rd_q[i]   <= rd_q[i-1];
        idx_q[i]  <= idx_q[i-1];
        op_q[i]   <= op_q[i-1];
      end
    end
  end

  assign res.valid = vld_q[LAST];
  assign res.rd    = rd_q[LAST];
  assign res.index = idx_q[LAST];
  assign res.wdata = (op_q[LAST] == exec_pkg::MUL_HI) ? prod_q[LAST][63:32] : prod_q[LAST][31:0];

endmodule

/* commit_latch.sv */
/*
  Execute-commit register for the arithmetic and multiply writeback groups
  and the branch outcome. Flush clears the valid bits, stall holds everything.
*/
`timescale 1ns/1ns

module commit_latch (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 flush,
  input  logic                 stall_commit,
  result_if.commit             arith,
  result_if.commit             mul,
  input  logic                 branch_valid,
  input  logic                 taken,
  input  exec_pkg::word_t      resolved_addr,
  output logic                 au_done,
  output logic                 mu_done,
  output logic                 br_valid,
  output logic                 br_taken,
  output exec_pkg::reg_idx_t   au_rd,
  output exec_pkg::reg_idx_t   mu_rd,
  output exec_pkg::cb_index_t  au_index,
  output exec_pkg::cb_index_t  mu_index,
  output exec_pkg::word_t      au_wdata,
  output exec_pkg::word_t      mu_wdata,
  output exec_pkg::word_t      br_resolved_addr
);

  // valid bits and branch outcome
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      au_done  <= 1'b0;
      mu_done  <= 1'b0;
      br_valid <= 1'b0;
      br_taken <= 1'b0;
    end else if (flush) begin
      au_done  <= 1'b0;
      mu_done  <= 1'b0;
      br_valid <= 1'b0;
      br_taken <= 1'b0;
    end else if (!stall_commit) begin
      au_done  <= arith.valid;
      mu_done  <= mul.valid;
      br_valid <= branch_valid;
      br_taken <= taken;
    end
  end

  // payload of both groups and the branch target
  always_ff @(posedge CLK) begin
    if (!stall_commit) begin
      au_rd            <= arith.rd;
      au_index         <= arith.index;
      au_wdata         <= arith.wdata;
      mu_rd            <= mul.rd;
      mu_index         <= mul.index;
      mu_wdata         <= mul.wdata;
      br_resolved_addr <= resolved_addr;
    end
  end

endmodule

/* exec_stage.sv */
/*
  Integer execute stage: ALU, branch resolution, pipelined multiplier
  and the execute-commit latch. Issue strobes are ignored during a commit stall.
*/
`timescale 1ns/1ns

module exec_stage #(
  parameter int MUL_STAGES = exec_pkg::MUL_STAGES_DEFAULT
) (
  input  logic                CLK,
  input  logic                nRST,
  // issue strobes
  input  logic                au_ena,
  input  logic                mul_ena,
  input  logic                branch_instr,
  input  logic                jump_instr,
  // operands and tags
  input  exec_pkg::word_t     port_a,
  input  exec_pkg::word_t     port_b,
  input  exec_pkg::word_t     immediate,
  input  exec_pkg::word_t     pc,
  input  exec_pkg::reg_idx_t  rd,
  input  exec_pkg::cb_index_t index,
  input  exec_pkg::alu_op_t   alu_op,
  input  exec_pkg::mul_op_t   mul_op,
  input  exec_pkg::br_cond_t  br_cond,
  input  logic                prediction,
  input  logic                jump_reg,
  input  logic                flush,
  input  logic                stall_commit,
  // commit side
  output logic                au_done,
  output exec_pkg::reg_idx_t  au_rd,
  output exec_pkg::cb_index_t au_index,
  output exec_pkg::word_t     au_wdata,
  output logic                mu_done,
  output exec_pkg::reg_idx_t  mu_rd,
  output exec_pkg::cb_index_t mu_index,
  output exec_pkg::word_t     mu_wdata,
  output logic                br_valid,
  output logic                br_taken,
  output exec_pkg::word_t     br_resolved_addr,
  // fetch redirect
  output logic                redirect,
  output exec_pkg::word_t     redirect_addr,
  output logic                mispredict_ff
);

  logic            au_go;
  logic            mul_go;
  logic            br_go;
  logic            jmp_go;
  logic            taken;
  exec_pkg::word_t resolved_addr;

  result_if arith_res ();
  result_if mul_res ();

  assign au_go  = au_ena & ~stall_commit;
  assign mul_go = mul_ena & ~stall_commit;
  assign br_go  = branch_instr & ~stall_commit;
  assign jmp_go = jump_instr & ~stall_commit;

  arith_unit u_arith (
    .au_ena(au_go), .jump_instr(jmp_go), .alu_op(alu_op),
    .port_a(port_a), .port_b(port_b), .pc(pc),
    .rd(rd), .index(index), .res(arith_res.unit)
  );

  branch_resolve u_branch (
    .CLK(CLK), .nRST(nRST),
    .branch_instr(br_go), .jump_instr(jmp_go), .jump_reg(jump_reg),
    .prediction(prediction), .br_cond(br_cond),
    .port_a(port_a), .port_b(port_b), .pc(pc), .immediate(immediate),
    .taken(taken), .resolved_addr(resolved_addr), .redirect_addr(redirect_addr),
    .redirect(redirect), .mispredict_ff(mispredict_ff)
  );

  mul_pipe #(.MUL_STAGES(MUL_STAGES)) u_mul (
    .CLK(CLK), .nRST(nRST), .mul_ena(mul_go), .stall(stall_commit), .flush(flush),
    .mul_op(mul_op), .port_a(port_a), .port_b(port_b),
    .rd(rd), .index(index), .res(mul_res.unit)
  );

  commit_latch u_latch (
    .CLK(CLK), .nRST(nRST), .flush(flush), .stall_commit(stall_commit),
    .arith(arith_res.commit), .mul(mul_res.commit),
    .branch_valid(br_go | jmp_go), .taken(taken), .resolved_addr(resolved_addr),
    .au_done(au_done), .mu_done(mu_done), .br_valid(br_valid), .br_taken(br_taken),
    .au_rd(au_rd), .mu_rd(mu_rd), .au_index(au_index), .mu_index(mu_index),
    .au_wdata(au_wdata), .mu_wdata(mu_wdata), .br_resolved_addr(br_resolved_addr)
  );

endmodule

/* exec_stage_assertions.sv */
/*
  Concurrent checks bound into exec_stage for the registered mispredict,
  flush and reset behavior.
*/
`timescale 1ns/1ns

module exec_stage_assertions (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic redirect,
  input logic mispredict_ff,
  input logic au_done,
  input logic mu_done,
  input logic br_valid
);

  int fail_count = 0;

  // registered copy lags redirect by one edge
  assert property (@(posedge CLK) disable iff (!nRST)
    $past(nRST) |-> mispredict_ff == $past(redirect))
  else begin
    fail_count++;
    $error("mispredict_ff does not follow redirect by one cycle");
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> !au_done && !mu_done && !br_valid)
  else begin
    fail_count++;
    $error("valid output still high the cycle after flush");
  end

  assert property (@(posedge CLK) !nRST && $past(!nRST) |-> !au_done && !mu_done && !br_valid)
  else begin
    fail_count++;
    $error("done output high during reset");
  end

endmodule

bind exec_stage exec_stage_assertions u_assertions (.*);

/* tb_exec_stage.sv */
/*
  Testbench for the integer execute stage. Random ALU, branch, jump and multiply
  traffic with stall and flush, checked against a cycle model at the falling edge.
*/
`timescale 1ns/1ns

module tb_exec_stage;

  localparam int MUL_STAGES = exec_pkg::MUL_STAGES_DEFAULT;

  logic CLK, nRST, au_ena, mul_ena, branch_instr, jump_instr;
  logic prediction, jump_reg, flush, stall_commit;
  exec_pkg::word_t port_a, port_b, immediate, pc;
  exec_pkg::reg_idx_t rd, au_rd, mu_rd;
  exec_pkg::cb_index_t index, au_index, mu_index;
  exec_pkg::alu_op_t alu_op;
  exec_pkg::mul_op_t mul_op;
  exec_pkg::br_cond_t br_cond;
  logic au_done, mu_done, br_valid, br_taken, redirect, mispredict_ff;
  exec_pkg::word_t au_wdata, mu_wdata, br_resolved_addr, redirect_addr, e_addr;

  // expected groups packed as {valid, 9 tag bits, data}
  logic [41:0] e_au, e_mu, e_br, mul_q[$];
  logic e_redir, cond, tk;
  int seed, errors, mul_pending, n;

  exec_stage #(.MUL_STAGES(MUL_STAGES)) uut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // codes 0-9 alu ops, 10/11 product halves, 16+funct3 branch compares
  function automatic exec_pkg::word_t ref_calc(input int code, input exec_pkg::word_t a,
                                               input exec_pkg::word_t b);
    logic [63:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    case (code)
      0: return a + b;
      1: return a - b;
      2: return a & b;
      3: return a | b;
      4: return a ^ b;
      5: return a << b[4:0];
      6: return a >> b[4:0];
      7: return $unsigned($signed(a) >>> b[4:0]);
      8: return 32'($signed(a) < $signed(b));
      9: return 32'(a < b);
      10: return prod[31:0];
      11: return prod[63:32];
      16: return 32'(a == b);
      17: return 32'(a != b);
      20: return 32'($signed(a) < $signed(b));
      21: return 32'($signed(a) >= $signed(b));
      22: return 32'(a < b);
      23: return 32'(a >= b);
      default: return 32'd0;
    endcase
  endfunction

  task automatic compare_group(input string name, input logic [41:0] exp,
                               input logic [41:0] got);
    if (exp[41] !== got[41] || (exp[41] && exp !== got)) begin
      errors++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
  endtask

  // drives one issue cycle just after the rising edge
  task automatic drive_cycle(input bit alu, input bit br, input bit jmp, input bit mul,
                             input bit stl, input bit fl);
    exec_pkg::word_t a, imm;
    int r, c;
    a = $random(seed);
    imm = $random(seed);
    r = $random(seed) & 32'h7fff_ffff;
    c = (r >> 16) % 6;
    @(posedge CLK);
    {au_ena, branch_instr, jump_instr} <= {alu, br, jmp};
    {mul_ena, stall_commit, flush} <= {mul, stl, fl};
    port_a <= a;
    // equal operands now and then so eq and ne go both ways
    port_b <= (r[3:0] == 4'd0) ? a : $random(seed);
    immediate <= {{20{imm[11]}}, imm[11:1], 1'b0};
    pc <= $random(seed) & 32'hffff_fffc;
    {rd, index, prediction, jump_reg} <= r[10:0];
    alu_op <= exec_pkg::alu_op_t'(4'(r % 10));
    mul_op <= exec_pkg::mul_op_t'(r[11]);
    br_cond <= exec_pkg::br_cond_t'(3'((c > 1) ? c + 2 : c));
  endtask

  // stage model compares at the falling edge where every signal has settled
  always @(negedge CLK) begin
    if (!nRST) begin
      {e_au, e_mu, e_br, e_redir} = '0;
      mul_pending = 0;
      mul_q = {};
      repeat (MUL_STAGES) mul_q.push_back('0);
    end else begin
      compare_group("au", e_au, {au_done, au_rd, au_index, au_wdata});
      compare_group("mu", e_mu, {mu_done, mu_rd, mu_index, mu_wdata});
      compare_group("br", e_br, {br_valid, 8'd0, br_taken, br_resolved_addr});
      compare_group("mispredict_ff", {1'b1, 40'd0, e_redir}, {1'b1, 40'd0, mispredict_ff});
      cond = ref_calc(16 + br_cond, port_a, port_b) != 0;
      tk = branch_instr & ~stall_commit & cond;
      e_redir = ~stall_commit & (jump_instr | (branch_instr & (cond != prediction)));
      e_addr = (jump_instr & ~stall_commit) ?
               (jump_reg ? (port_a + immediate) & ~32'd1 : pc + immediate) :
               (e_redir & tk) ? pc + immediate : pc + 32'd4;
      compare_group("redirect", {1'b1, 8'd0, e_redir, e_addr},
                    {1'b1, 8'd0, redirect, redirect_addr});
      if (flush) begin
        {e_au, e_mu, e_br} = '0;
        mul_pending = 0;
        foreach (mul_q[i]) mul_q[i][41] = 1'b0;
      end else if (!stall_commit) begin
        e_au = {au_ena | jump_instr, rd, index,
                jump_instr ? pc + 32'd4 : ref_calc(alu_op, port_a, port_b)};
        e_br = {branch_instr | jump_instr, 8'd0, tk, tk ? pc + immediate : pc + 32'd4};
        e_mu = mul_q.pop_front();
        mul_q.push_back({mul_ena, rd, index, ref_calc(10 + mul_op, port_a, port_b)});
        mul_pending = mul_pending + int'(mul_ena) - int'(e_mu[41]);
      end
    end
  end

  initial begin
    seed = 27060;
    errors = 0;
    nRST = 1'b0;
    {au_ena, mul_ena, branch_instr, jump_instr, prediction, jump_reg, flush, stall_commit} = '0;
    {port_a, port_b, immediate, pc, rd, index} = '0;
    alu_op = exec_pkg::ALU_ADD;
    mul_op = exec_pkg::MUL_LO;
    br_cond = exec_pkg::BR_EQ;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    if ({au_done, mu_done, br_valid, br_taken, mispredict_ff} !== 5'b0) begin
      errors++;
      $display("Error at %0t ns: outputs not cleared by reset", $time);
    end
    repeat (80) begin
      n = $random(seed) & 32'h7fff_ffff;
      drive_cycle(n % 3 == 0, n % 3 == 1, n % 3 == 2, 1'b0, 1'b0, 1'b0);
    end
    // back-to-back multiplies with alu traffic alongside
    repeat (24) drive_cycle(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    repeat (5) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    repeat (3) drive_cycle(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    // the alu op issued with the flush must not reach au_done
    drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    // flush wins over a stall in the same cycle
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    n = 0;
    while (mul_pending != 0 && n < 20) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      n++;
    end
    if (mul_pending != 0) begin
      errors++;
      $display("Timeout: multiply results still pending after 20 idle cycles");
    end
    repeat (2) @(negedge CLK);
    $display("%0d errors, %0d assertion failures", errors, uut.u_assertions.fail_count);
    if (errors == 0 && uut.u_assertions.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
exec_pkg.sv
result_if.sv
arith_unit.sv
branch_resolve.sv
mul_pipe.sv
commit_latch.sv
exec_stage.sv
exec_stage_assertions.sv
tb_exec_stage.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - exec_pkg.sv
  - result_if.sv
  - arith_unit.sv
  - branch_resolve.sv
  - mul_pipe.sv
  - commit_latch.sv
  - exec_stage.sv
  - target: test
    files:
      - exec_stage_assertions.sv
      - tb_exec_stage.sv
